// ==== rtl/bk_bus_pkg.sv ====
`default_nettype none

package bk_bus_pkg;

    // ------------------------------------------------------------
    // CPU bus geometry
    // ------------------------------------------------------------
    localparam int VADDR_W = 16;                      // cpu address width
    localparam int DATA_W  = 16;                      // data width

    localparam logic [8:0] REG_PAGE = 9'b111_111_111; // addr[15:7] of 177600..177776

    // ------------------------------------------------------------
    // register offsets inside the page, addr[6:0]
    // ------------------------------------------------------------
    localparam logic [6:0] OFS_KBD_STATE = 7'o060;    // 177660
    localparam logic [6:0] OFS_KBD_DATA  = 7'o062;    // 177662
    localparam logic [6:0] OFS_ROLL      = 7'o064;    // 177664
    localparam logic [6:0] OFS_MMUCTRL   = 7'o100;    // 177700
    localparam logic [6:0] OFS_USRREG    = 7'o114;    // 177714
    localparam logic [6:0] OFS_INITREG   = 7'o116;    // 177716

    // reset values and constants
    localparam logic [15:0] ROLL_RESET = 16'o001330;  // full screen, default scroll
    localparam logic [7:0]  INIT_HI    = 8'h80;       // start address msb

    // keyboard interrupt vectors
    localparam logic [15:0] VEC_KBD     = 16'o000060;
    localparam logic [15:0] VEC_KBD_AR2 = 16'o000274; // AR2 held

endpackage

`default_nettype wire

// ==== rtl/bk_mmu_pkg.sv ====
`default_nettype none

package bk_mmu_pkg;

    // ------------------------------------------------------------
    // page geometry
    // ------------------------------------------------------------
    localparam int PAGE_BITS = 13;                    // 8 KB pages
    localparam int PAGES     = 8;                     // per mode, kernel and user
    localparam int FRAME_W   = 9;                     // frame number field

    // page register layout
    localparam int PR_WRITABLE = 15;                  // write enable flag

    // ------------------------------------------------------------
    // MMU control register, 177700
    // ------------------------------------------------------------
    localparam int CTL_SHADOW   = 0;                  // boot area writable
    localparam int CTL_MMU_EN   = 1;                  // translation on
    localparam int CTL_MODE_REQ = 2;                  // requested cpu mode

endpackage

`default_nettype wire

// ==== rtl/bk_sysregs.sv ====
`timescale 1ns/100ps
`default_nettype none

module bk_sysregs (
    input  wire                            clk,
    input  wire                            reset_n,
    input  wire [bk_bus_pkg::VADDR_W-1:0]  cpu_addr_i,
    input  wire [bk_bus_pkg::DATA_W-1:0]   cpu_wdata_i,
    input  wire                            cpu_rd_i,
    input  wire                            cpu_wt_i,
    input  wire                            cpu_iack_i,
    input  wire                            wr_fault_i,      // forbidden memory write
    input  wire [bk_bus_pkg::DATA_W-1:0]   mmu_rdata_i,
    input  wire                            cpu_mode_i,
    input  wire                            kbd_valid_i,
    input  wire [7:0]                      kbd_code_i,
    input  wire                            kbd_ar2_i,
    input  wire                            stop_key_i,
    input  wire                            keydown_i,
    input  wire                            tape_in_i,
    input  wire                            spi_dsr_i,
    input  wire [7:0]                      spi_di_i,
    output logic                           reg_hit_o,
    output logic [bk_bus_pkg::DATA_W-1:0]  reg_rdata_o,
    output logic                           reg_rply_o,
    output logic                           reg_error_o,
    output logic                           shadow_o,
    output logic                           mmu_en_o,
    output logic                           mode_req_o,
    output logic                           page_wr_o,
    output logic                           kbd_ack_o,
    output logic                           irq_o,
    output logic [7:0]                     roll_o,
    output logic                           full_screen_o,
    output logic                           tape_out_o,
    output logic                           spi_wren_o,
    output logic [7:0]                     spi_do_o,
    output logic                           spi_cs_n_o
);

    localparam logic [2:0] CTL_RESET = 3'(1 << bk_mmu_pkg::CTL_SHADOW);

    logic       page_hit;
    logic [6:0] ofs;
    logic       sel_kbd_state, sel_kbd_data, sel_roll, sel_mmuctrl;
    logic       sel_usr, sel_init, sel_page;
    logic       bad_ofs;
    logic       req, start, acked;
    logic       reg_rd, reg_wr;
    logic       kbd_int_dis;                               // 177660 bit 6
    logic       roll_hi;                                   // roll bit 9
    logic [7:0] roll_lo;
    logic [2:0] mmu_ctl;
    logic       stop_latch;

    // ------------------------------------------------------------
    // page decode
    // ------------------------------------------------------------
    assign page_hit = (cpu_addr_i[15:7] == bk_bus_pkg::REG_PAGE);
    assign ofs      = cpu_addr_i[6:0];

    assign sel_kbd_state = (ofs == bk_bus_pkg::OFS_KBD_STATE);
    assign sel_kbd_data  = (ofs == bk_bus_pkg::OFS_KBD_DATA);
    assign sel_roll      = (ofs == bk_bus_pkg::OFS_ROLL);
    assign sel_mmuctrl   = (ofs == bk_bus_pkg::OFS_MMUCTRL);
    assign sel_usr       = (ofs == bk_bus_pkg::OFS_USRREG);
    assign sel_init      = (ofs == bk_bus_pkg::OFS_INITREG);
    assign sel_page      = (ofs[6:5] == 2'b00);            // 177600..177636

    assign bad_ofs = ~(sel_kbd_state | sel_kbd_data | sel_roll | sel_mmuctrl |
                       sel_usr | sel_init | sel_page);

    assign reg_hit_o = page_hit | cpu_iack_i;              // vector comes from here too

    // one answer per strobe, acked holds until the master drops it
    assign req    = (page_hit & (cpu_rd_i | cpu_wt_i)) | cpu_iack_i | wr_fault_i;
    assign start  = req & ~acked;
    assign reg_rd = start & cpu_rd_i & page_hit;
    assign reg_wr = start & cpu_wt_i & page_hit & ~bad_ofs;

    assign page_wr_o = reg_wr & sel_page;

    // ------------------------------------------------------------
    // control state and registers
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acked       <= 1'b0;
            reg_rply_o  <= 1'b0;
            reg_error_o <= 1'b0;
            kbd_ack_o   <= 1'b0;
            spi_wren_o  <= 1'b0;
            kbd_int_dis <= 1'b0;
            roll_hi     <= bk_bus_pkg::ROLL_RESET[9];
            roll_lo     <= bk_bus_pkg::ROLL_RESET[7:0];
            mmu_ctl     <= CTL_RESET;
            tape_out_o  <= 1'b0;
            spi_cs_n_o  <= 1'b1;
            stop_latch  <= 1'b0;
        end else begin
            acked       <= req;
            reg_rply_o  <= start & ~wr_fault_i & (cpu_iack_i | ~bad_ofs);
            reg_error_o <= start & (wr_fault_i | (~cpu_iack_i & bad_ofs));
            kbd_ack_o   <= reg_rd & sel_kbd_data;          // key taken by the cpu
            spi_wren_o  <= reg_wr & sel_usr;

            if (reg_rd & sel_init) begin
                stop_latch <= 1'b0;
            end else if (stop_key_i) begin
                stop_latch <= 1'b1;
            end

            if (reg_wr) begin
                if (sel_kbd_state) begin
                    kbd_int_dis <= cpu_wdata_i[6];
                end
                if (sel_roll) begin
                    roll_hi <= cpu_wdata_i[9];
                    roll_lo <= cpu_wdata_i[7:0];
                end
                if (sel_init) begin
                    tape_out_o <= cpu_wdata_i[6];
                    spi_cs_n_o <= cpu_wdata_i[0];
                end
                if (sel_mmuctrl) begin
                    mmu_ctl <= cpu_wdata_i[2:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reg_wr & sel_usr) begin
            spi_do_o <= cpu_wdata_i[7:0];                  // spi byte out
        end
    end

    // ------------------------------------------------------------
    // read data
    // ------------------------------------------------------------
    always_comb begin
        reg_rdata_o = '0;
        if (cpu_iack_i) begin
            reg_rdata_o = kbd_ar2_i ? bk_bus_pkg::VEC_KBD_AR2 : bk_bus_pkg::VEC_KBD;
        end else if (sel_page) begin
            reg_rdata_o = mmu_rdata_i;
        end else if (sel_kbd_state) begin
            reg_rdata_o = {8'b0, kbd_valid_i, kbd_int_dis, 6'b0};
        end else if (sel_kbd_data) begin
            reg_rdata_o = {8'b0, kbd_code_i};
        end else if (sel_roll) begin
            reg_rdata_o = {6'b0, roll_hi, 1'b0, roll_lo};
        end else if (sel_mmuctrl) begin
            reg_rdata_o = {12'b0, cpu_mode_i, mmu_ctl};    // mode seen in bit 3
        end else if (sel_usr) begin
            reg_rdata_o = {7'b0, ~spi_dsr_i, spi_di_i};
        end else if (sel_init) begin
            reg_rdata_o = {bk_bus_pkg::INIT_HI, 1'b1, ~keydown_i, tape_in_i, 2'b0,
                           stop_latch, 2'b0};
        end
    end

    assign shadow_o      = mmu_ctl[bk_mmu_pkg::CTL_SHADOW];
    assign mmu_en_o      = mmu_ctl[bk_mmu_pkg::CTL_MMU_EN];
    assign mode_req_o    = mmu_ctl[bk_mmu_pkg::CTL_MODE_REQ];
    assign irq_o         = kbd_valid_i & ~kbd_int_dis;
    assign roll_o        = roll_lo;
    assign full_screen_o = roll_hi;

    a_rply_xor_error: assert property (@(posedge clk) disable iff (!reset_n)
        !(reg_rply_o && reg_error_o))
        else $error("register reply and error together");

    a_ack_in_rply: assert property (@(posedge clk) disable iff (!reset_n)
        kbd_ack_o |-> reg_rply_o)
        else $error("keyboard ack outside a register reply");

endmodule

`default_nettype wire

// ==== rtl/bk_memmap.sv ====
`timescale 1ns/100ps
`default_nettype none

module bk_memmap #(
    parameter int PHYS_ADDR_W = 22
) (
    input  wire                            clk,
    input  wire                            reset_n,
    input  wire [bk_bus_pkg::VADDR_W-1:0]  vaddr_i,
    input  wire [bk_bus_pkg::DATA_W-1:0]   wdata_i,
    input  wire                            page_wr_i,
    input  wire                            enable_i,
    input  wire                            mode_i,        // 1 user, 0 kernel
    output logic [bk_bus_pkg::DATA_W-1:0]  rdata_o,
    output logic [PHYS_ADDR_W-1:0]         phys_addr_o,
    output logic                           writable_o
);

    localparam int PAGES     = bk_mmu_pkg::PAGES;
    localparam int IDX_W     = $clog2(PAGES);
    localparam int PAGE_BITS = bk_mmu_pkg::PAGE_BITS;
    localparam int VA_W      = bk_bus_pkg::VADDR_W;

    if (PHYS_ADDR_W != bk_mmu_pkg::FRAME_W + PAGE_BITS) begin : g_width_check
        $error("PHYS_ADDR_W must equal FRAME_W + PAGE_BITS");
    end

    logic [bk_bus_pkg::DATA_W-1:0] page_q [2*PAGES];    // kernel 0..7, user 8..15
    logic [IDX_W:0]                reg_idx;
    logic [IDX_W:0]                map_idx;
    logic [bk_bus_pkg::DATA_W-1:0] cur_pr;

    // ------------------------------------------------------------
    // page tables
    // ------------------------------------------------------------
    assign reg_idx = {vaddr_i[IDX_W+1], vaddr_i[IDX_W:1]};  // bit 4 picks user set

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < 2*PAGES; i++) begin
                page_q[i] <= '0;
            end
        end else if (page_wr_i) begin
            page_q[reg_idx] <= wdata_i;
        end
    end

    assign rdata_o = page_q[reg_idx];

    // ------------------------------------------------------------
    // translation
    // ------------------------------------------------------------
    assign map_idx = {mode_i, vaddr_i[VA_W-1:PAGE_BITS]};
    assign cur_pr  = page_q[map_idx];

    always_comb begin
        if (enable_i) begin
            phys_addr_o = {cur_pr[bk_mmu_pkg::FRAME_W-1:0], vaddr_i[PAGE_BITS-1:0]};
            writable_o  = cur_pr[bk_mmu_pkg::PR_WRITABLE];
        end else begin
            phys_addr_o = PHYS_ADDR_W'(vaddr_i);          // flat 64K map
            writable_o  = ~vaddr_i[VA_W-1];               // upper half is rom
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bk_bus_steer.sv ====
`timescale 1ns/100ps
`default_nettype none

module bk_bus_steer #(
    parameter int PHYS_ADDR_W = 22
) (
    input  wire [bk_bus_pkg::VADDR_W-1:0]  cpu_addr_i,
    input  wire [bk_bus_pkg::DATA_W-1:0]   cpu_wdata_i,
    input  wire                            cpu_rd_i,
    input  wire                            cpu_wt_i,
    input  wire                            cpu_byte_i,
    input  wire                            reg_hit_i,
    input  wire [bk_bus_pkg::DATA_W-1:0]   reg_rdata_i,
    input  wire                            reg_rply_i,
    input  wire                            reg_error_i,
    input  wire [PHYS_ADDR_W-1:0]          phys_addr_i,
    input  wire                            writable_i,
    input  wire                            shadow_i,
    input  wire [bk_bus_pkg::DATA_W-1:0]   mem_rdata_i,
    input  wire                            mem_reply_i,
    output logic [PHYS_ADDR_W-1:0]         mem_addr_o,
    output logic                           mem_rd_o,
    output logic                           mem_wt_o,
    output logic                           mem_byte_o,
    output logic [bk_bus_pkg::DATA_W-1:0]  mem_wdata_o,
    output logic [bk_bus_pkg::DATA_W-1:0]  cpu_rdata_o,
    output logic                           cpu_rply_o,
    output logic                           wr_fault_o
);

    logic wr_ok;
    logic odd_byte;

    // ------------------------------------------------------------
    // memory strobes
    // ------------------------------------------------------------
    assign wr_ok    = writable_i | (shadow_i & cpu_addr_i[15]);   // boot area in shadow
    assign odd_byte = cpu_byte_i & cpu_addr_i[0];

    assign mem_addr_o  = phys_addr_i;
    assign mem_byte_o  = cpu_byte_i;
    assign mem_rd_o    = cpu_rd_i & ~reg_hit_i;
    assign mem_wt_o    = cpu_wt_i & ~reg_hit_i & wr_ok;
    assign wr_fault_o  = cpu_wt_i & ~reg_hit_i & ~wr_ok;
    assign mem_wdata_o = odd_byte ? {cpu_wdata_i[7:0], cpu_wdata_i[7:0]} : cpu_wdata_i;

    // reply merge, error is reported on its own line
    assign cpu_rply_o = (reg_rply_i & ~reg_error_i) | (mem_reply_i & (mem_rd_o | mem_wt_o));

    always_comb begin
        if (reg_hit_i) begin
            cpu_rdata_o = reg_rdata_i;
        end else if (!cpu_byte_i) begin
            cpu_rdata_o = mem_rdata_i;
        end else if (cpu_addr_i[0]) begin
            cpu_rdata_o = {8'b0, mem_rdata_i[15:8]};     // odd byte
        end else begin
            cpu_rdata_o = {8'b0, mem_rdata_i[7:0]};
        end
    end

    always_comb begin
        a_one_strobe: assert (!(mem_rd_o && mem_wt_o))
            else $error("memory read and write strobes together");
    end

endmodule

`default_nettype wire

// ==== rtl/bk_core_io.sv ====
`timescale 1ns/100ps
`default_nettype none

module bk_core_io #(
    parameter int PHYS_ADDR_W = 22
) (
    input  wire                            clk,
    input  wire                            reset_n,
    // cpu bus
    input  wire [bk_bus_pkg::VADDR_W-1:0]  cpu_addr_i,
    input  wire [bk_bus_pkg::DATA_W-1:0]   cpu_wdata_i,
    input  wire                            cpu_rd_i,
    input  wire                            cpu_wt_i,
    input  wire                            cpu_byte_i,
    input  wire                            cpu_iack_i,
    input  wire                            cpu_mode_i,   // psw bit 15
    output logic [bk_bus_pkg::DATA_W-1:0]  cpu_rdata_o,
    output logic                           cpu_rply_o,
    output logic                           cpu_error_o,
    output logic                           mode_req_o,
    // memory
    output logic [PHYS_ADDR_W-1:0]         mem_addr_o,
    output logic                           mem_rd_o,
    output logic                           mem_wt_o,
    output logic                           mem_byte_o,
    output logic [bk_bus_pkg::DATA_W-1:0]  mem_wdata_o,
    input  wire  [bk_bus_pkg::DATA_W-1:0]  mem_rdata_i,
    input  wire                            mem_reply_i,
    // keyboard, screen, tape
    input  wire                            kbd_valid_i,
    input  wire  [7:0]                     kbd_code_i,
    input  wire                            kbd_ar2_i,
    input  wire                            stop_key_i,
    input  wire                            keydown_i,
    input  wire                            tape_in_i,
    output logic                           kbd_ack_o,
    output logic                           irq_o,
    output logic [7:0]                     roll_o,
    output logic                           full_screen_o,
    output logic                           tape_out_o,
    // user port
    input  wire                            spi_dsr_i,
    input  wire  [7:0]                     spi_di_i,
    output logic                           spi_wren_o,
    output logic [7:0]                     spi_do_o,
    output logic                           spi_cs_n_o
);

    logic                          reg_hit, reg_rply, reg_error, wr_fault;
    logic [bk_bus_pkg::DATA_W-1:0] reg_rdata, mmu_rdata;
    logic                          shadow, mmu_en, page_wr, writable;
    logic [PHYS_ADDR_W-1:0]        phys_addr;

    assign cpu_error_o = reg_error;

    bk_sysregs u_sysregs (
        .clk(clk), .reset_n(reset_n),
        .cpu_addr_i(cpu_addr_i), .cpu_wdata_i(cpu_wdata_i),
        .cpu_rd_i(cpu_rd_i), .cpu_wt_i(cpu_wt_i), .cpu_iack_i(cpu_iack_i),
        .wr_fault_i(wr_fault), .mmu_rdata_i(mmu_rdata), .cpu_mode_i(cpu_mode_i),
        .kbd_valid_i(kbd_valid_i), .kbd_code_i(kbd_code_i), .kbd_ar2_i(kbd_ar2_i),
        .stop_key_i(stop_key_i), .keydown_i(keydown_i), .tape_in_i(tape_in_i),
        .spi_dsr_i(spi_dsr_i), .spi_di_i(spi_di_i),
        .reg_hit_o(reg_hit), .reg_rdata_o(reg_rdata),
        .reg_rply_o(reg_rply), .reg_error_o(reg_error),
        .shadow_o(shadow), .mmu_en_o(mmu_en), .mode_req_o(mode_req_o),
        .page_wr_o(page_wr), .kbd_ack_o(kbd_ack_o), .irq_o(irq_o),
        .roll_o(roll_o), .full_screen_o(full_screen_o), .tape_out_o(tape_out_o),
        .spi_wren_o(spi_wren_o), .spi_do_o(spi_do_o), .spi_cs_n_o(spi_cs_n_o)
    );

    bk_memmap #(.PHYS_ADDR_W(PHYS_ADDR_W)) u_memmap (
        .clk(clk), .reset_n(reset_n),
        .vaddr_i(cpu_addr_i), .wdata_i(cpu_wdata_i), .page_wr_i(page_wr),
        .enable_i(mmu_en), .mode_i(cpu_mode_i),
        .rdata_o(mmu_rdata), .phys_addr_o(phys_addr), .writable_o(writable)
    );

    bk_bus_steer #(.PHYS_ADDR_W(PHYS_ADDR_W)) u_bus_steer (
        .cpu_addr_i(cpu_addr_i), .cpu_wdata_i(cpu_wdata_i),
        .cpu_rd_i(cpu_rd_i), .cpu_wt_i(cpu_wt_i), .cpu_byte_i(cpu_byte_i),
        .reg_hit_i(reg_hit), .reg_rdata_i(reg_rdata),
        .reg_rply_i(reg_rply), .reg_error_i(reg_error),
        .phys_addr_i(phys_addr), .writable_i(writable), .shadow_i(shadow),
        .mem_rdata_i(mem_rdata_i), .mem_reply_i(mem_reply_i),
        .mem_addr_o(mem_addr_o), .mem_rd_o(mem_rd_o), .mem_wt_o(mem_wt_o),
        .mem_byte_o(mem_byte_o), .mem_wdata_o(mem_wdata_o),
        .cpu_rdata_o(cpu_rdata_o), .cpu_rply_o(cpu_rply_o), .wr_fault_o(wr_fault)
    );

endmodule

`default_nettype wire

// ==== sim/tb_bk_model.svh ====
`ifndef TB_BK_MODEL_SVH
`define TB_BK_MODEL_SVH

// ------------------------------------------------------------
// reference state of the register page
// ------------------------------------------------------------
logic [15:0] m_pt [16];                 // kernel 0..7, user 8..15
logic        m_shadow;
logic        m_mmu_en;
logic        m_mode_req;
logic        m_kbd_dis;
logic        m_roll_hi;
logic [7:0]  m_roll_lo;

task automatic model_reset();
    for (int i = 0; i < 16; i++) begin
        m_pt[i] = 16'h0000;
    end
    m_shadow   = 1'b1;                  // boot area writable out of reset
    m_mmu_en   = 1'b0;
    m_mode_req = 1'b0;
    m_kbd_dis  = 1'b0;
    m_roll_hi  = 1'b1;                  // 01330
    m_roll_lo  = 8'hd8;
endtask

task automatic model_ctl_write(input logic [2:0] d);
    m_shadow   = d[0];
    m_mmu_en   = d[1];
    m_mode_req = d[2];
endtask

// memory contents, every address bit takes part
function automatic logic [15:0] mem_word(input logic [21:0] pa);
    return pa[15:0] ^ {pa[21:16], pa[21:16], pa[3:0]};
endfunction

function automatic logic [21:0] exp_phys(input logic [15:0] va, input logic mode);
    if (m_mmu_en) begin
        return {m_pt[{mode, va[15:13]}][8:0], va[12:0]};
    end
    return {6'b0, va};
endfunction

function automatic logic exp_writable(input logic [15:0] va, input logic mode);
    logic w;
    w = m_mmu_en ? m_pt[{mode, va[15:13]}][15] : ~va[15];
    return w | (m_shadow & va[15]);     // shadow opens the upper half
endfunction

function automatic logic [15:0] exp_read(input logic [15:0] word, input logic [15:0] va,
                                         input logic byte_m);
    if (!byte_m) begin
        return word;
    end
    return va[0] ? {8'h00, word[15:8]} : {8'h00, word[7:0]};
endfunction

function automatic logic [15:0] exp_wdata(input logic [15:0] d, input logic [15:0] va,
                                          input logic byte_m);
    return (byte_m && va[0]) ? {d[7:0], d[7:0]} : d;
endfunction

`endif

// ==== sim/tb_bk_core_io.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_bk_core_io;

    localparam int N_XLAT  = 48;
    localparam int N_WR    = 48;
    localparam int N_TRANS = 32 + 2*N_XLAT + 2*N_WR + 40;
    localparam int BUS_LIMIT = 16;                          // cycles per access

    logic clk, reset_n;
    logic [15:0] cpu_addr_i, cpu_wdata_i, mem_rdata_i, cpu_rdata_o, mem_wdata_o;
    logic cpu_rd_i, cpu_wt_i, cpu_byte_i, cpu_iack_i, cpu_mode_i, mem_reply_i;
    logic cpu_rply_o, cpu_error_o, mode_req_o, mem_rd_o, mem_wt_o, mem_byte_o;
    logic [21:0] mem_addr_o;
    logic kbd_valid_i, kbd_ar2_i, stop_key_i, keydown_i, tape_in_i, spi_dsr_i;
    logic [7:0] kbd_code_i, spi_di_i, roll_o, spi_do_o;
    logic kbd_ack_o, irq_o, full_screen_o, tape_out_o, spi_wren_o, spi_cs_n_o;

    logic [31:0] lfsr_q, resp_q;
    logic [15:0] got_rdata, got_wdata;
    logic [21:0] got_maddr;
    logic        got_err, got_mrd, got_mbyte, wt_any, got_kack, got_wren;
    logic [1:0]  resp_wait;

    `include "tb_bk_model.svh"

    bk_core_io #(.PHYS_ADDR_W(22)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(inout logic [31:0] st, input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], st[0]};
            st = st[0] ? ((st >> 1) ^ 32'h8020_0003) : (st >> 1);
        end
        return r;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            stop_run("check failed");
        end
    endtask

    // ------------------------------------------------------------
    // cpu bus master doing one access until rply or error
    // ------------------------------------------------------------
    task automatic bus_xfer(input logic [15:0] addr, input logic [15:0] wdata,
                            input logic wr, input logic byte_m, input logic iack,
                            input logic mode);
        int n;
        logic done;
        n = 0;
        done = 1'b0;
        wt_any = 1'b0;
        @(posedge clk);
        cpu_addr_i  <= addr;
        cpu_wdata_i <= wdata;
        cpu_byte_i  <= byte_m;
        cpu_mode_i  <= mode;
        cpu_rd_i    <= !wr && !iack;
        cpu_wt_i    <= wr;
        cpu_iack_i  <= iack;
        while (!done) begin
            @(negedge clk);
            wt_any = wt_any | mem_wt_o;
            if (cpu_rply_o || cpu_error_o) begin
                done = 1'b1;
            end else begin
                n++;
                if (n > BUS_LIMIT) stop_run("bus access got neither reply nor error");
            end
        end
        got_rdata = cpu_rdata_o;
        got_err   = cpu_error_o;
        got_maddr = mem_addr_o;
        got_wdata = mem_wdata_o;
        got_mrd   = mem_rd_o;
        got_mbyte = mem_byte_o;
        got_kack  = kbd_ack_o;
        got_wren  = spi_wren_o;
        @(posedge clk);
        cpu_rd_i   <= 1'b0;
        cpu_wt_i   <= 1'b0;
        cpu_iack_i <= 1'b0;
        @(posedge clk);                                    // strobe low one cycle
    endtask

    task automatic reg_write(input logic [6:0] ofs, input logic [15:0] d);
        bus_xfer({9'h1ff, ofs}, d, 1'b1, 1'b0, 1'b0, cpu_mode_i);
        check("cpu_error_o", got_err, 0);
    endtask

    task automatic reg_read(input logic [6:0] ofs, input logic mode, input logic [15:0] exp);
        bus_xfer({9'h1ff, ofs}, 16'h0, 1'b0, 1'b0, 1'b0, mode);
        check("cpu_error_o", got_err, 0);
        check("cpu_rdata_o", got_rdata, exp);
    endtask

    // memory model with a random reply delay
    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_reply_i <= 1'b0;
            resp_wait   <= 2'd0;
        end else if (!(mem_rd_o || mem_wt_o)) begin
            mem_reply_i <= 1'b0;
            resp_wait   <= 2'(rand_bits(resp_q, 2));
        end else if (!mem_reply_i) begin
            if (resp_wait == 0) mem_reply_i <= 1'b1;
            else resp_wait <= resp_wait - 2'd1;
        end
    end

    assign mem_rdata_i = mem_word(mem_addr_o);

    initial begin
        repeat (8 + N_TRANS * 20) @(posedge clk);
        stop_run("watchdog expired before the tests completed");
    end

    initial begin
        logic [15:0] a, d;
        logic        md, bm, w;
        lfsr_q = 32'h0786_24f0;
        resp_q = 32'h0786_24f0;
        reset_n <= 1'b0;
        cpu_addr_i  <= '0;
        cpu_wdata_i <= '0;
        cpu_rd_i    <= 1'b0;
        cpu_wt_i    <= 1'b0;
        cpu_byte_i  <= 1'b0;
        cpu_iack_i  <= 1'b0;
        cpu_mode_i  <= 1'b0;
        kbd_valid_i <= 1'b0;
        kbd_code_i  <= '0;
        kbd_ar2_i   <= 1'b0;
        stop_key_i  <= 1'b0;
        keydown_i   <= 1'b0;
        tape_in_i   <= 1'b0;
        spi_dsr_i   <= 1'b0;
        spi_di_i    <= '0;
        model_reset();
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        reg_read(7'o064, 1'b0, {6'b0, m_roll_hi, 1'b0, m_roll_lo});
        reg_read(7'o100, 1'b0, 16'h0001);

        // ---------------- page tables
        for (int i = 0; i < 16; i++) begin
            m_pt[i] = 16'(rand_bits(lfsr_q, 16));
            reg_write(7'(2 * i), m_pt[i]);
        end
        for (int i = 0; i < 16; i++) reg_read(7'(2 * i), 1'b0, m_pt[i]);

        // ---------------- translation, mmu on then off
        for (int pass = 0; pass < 2; pass++) begin
            model_ctl_write(pass == 0 ? 3'b010 : 3'b000);
            reg_write(7'o100, {13'b0, m_mode_req, m_mmu_en, m_shadow});
            for (int i = 0; i < N_XLAT; i++) begin
                md = 1'(rand_bits(lfsr_q, 1));
                bm = 1'(rand_bits(lfsr_q, 1));
                a  = 16'(rand_bits(lfsr_q, 16));
                if (a[15:7] == 9'h1ff) a[7] = 1'b0;        // stay off the register page
                bus_xfer(a, 16'h0, 1'b0, bm, 1'b0, md);
                check("mem_rd_o", got_mrd, 1);
                check("mem_byte_o", got_mbyte, bm);
                check("mem_addr_o", got_maddr, exp_phys(a, md));
                check("cpu_rdata_o", got_rdata, exp_read(mem_word(exp_phys(a, md)), a, bm));
            end
        end

        // ---------------- write gating, shadow off then on
        for (int pass = 0; pass < 2; pass++) begin
            model_ctl_write(pass == 0 ? 3'b010 : 3'b011);
            reg_write(7'o100, {13'b0, m_mode_req, m_mmu_en, m_shadow});
            for (int i = 0; i < N_WR; i++) begin
                md = 1'(rand_bits(lfsr_q, 1));
                bm = 1'(rand_bits(lfsr_q, 1));
                a  = 16'(rand_bits(lfsr_q, 16));
                d  = 16'(rand_bits(lfsr_q, 16));
                if (a[15:7] == 9'h1ff) a[7] = 1'b0;
                w = exp_writable(a, md);
                bus_xfer(a, d, 1'b1, bm, 1'b0, md);
                check("cpu_error_o", got_err, !w);
                check("mem_wt_o", wt_any, w);
                if (w) begin
                    check("mem_addr_o", got_maddr, exp_phys(a, md));
                    check("mem_byte_o", got_mbyte, bm);
                    check("mem_wdata_o", got_wdata, exp_wdata(d, a, bm));
                end
            end
        end

        // ---------------- system registers
        d = 16'(rand_bits(lfsr_q, 16));
        reg_write(7'o064, d);
        reg_read(7'o064, 1'b0, {6'b0, d[9], 1'b0, d[7:0]});
        check("roll_o", roll_o, d[7:0]);
        check("full_screen_o", full_screen_o, d[9]);
        d = 16'(rand_bits(lfsr_q, 3));
        md = 1'(rand_bits(lfsr_q, 1));
        reg_write(7'o100, d);
        reg_read(7'o100, md, {12'b0, md, d[2:0]});
        check("mode_req_o", mode_req_o, d[2]);
        bus_xfer(16'o177640, 16'h0, 1'b0, 1'b0, 1'b0, 1'b0);
        check("cpu_error_o", got_err, 1);

        // ---------------- keyboard
        @(posedge clk);
        kbd_code_i  <= 8'(rand_bits(lfsr_q, 8));
        kbd_valid_i <= 1'b1;
        kbd_ar2_i   <= 1'(rand_bits(lfsr_q, 1));
        @(posedge clk);
        reg_read(7'o062, 1'b0, {8'h00, kbd_code_i});
        check("kbd_ack_o", got_kack, 1);
        check("kbd_ack_o", kbd_ack_o, 0);                  // single pulse
        for (int i = 0; i < 2; i++) begin
            m_kbd_dis = (i == 0);
            reg_write(7'o060, {9'b0, m_kbd_dis, 6'b0});
            reg_read(7'o060, 1'b0, {8'h00, 1'b1, m_kbd_dis, 6'b0});
            check("irq_o", irq_o, !m_kbd_dis);
        end
        for (int i = 0; i < 2; i++) begin
            @(posedge clk);
            kbd_ar2_i <= ~kbd_ar2_i;                       // both vectors
            bus_xfer(16'h0, 16'h0, 1'b0, 1'b0, 1'b1, 1'b0);
            check("cpu_rdata_o", got_rdata, kbd_ar2_i ? 16'o000274 : 16'o000060);
        end

        // ---------------- spi and init
        d = 16'(rand_bits(lfsr_q, 16));
        reg_write(7'o114, d);
        check("spi_wren_o", got_wren, 1);
        check("spi_wren_o", spi_wren_o, 0);
        check("spi_do_o", spi_do_o, d[7:0]);
        @(posedge clk);
        spi_dsr_i <= 1'(rand_bits(lfsr_q, 1));
        spi_di_i  <= 8'(rand_bits(lfsr_q, 8));
        @(posedge clk);
        reg_read(7'o114, 1'b0, {7'b0, ~spi_dsr_i, spi_di_i});
        d = 16'(rand_bits(lfsr_q, 16));
        for (int i = 0; i < 2; i++) begin
            reg_write(7'o116, d);
            check("spi_cs_n_o", spi_cs_n_o, d[0]);
            check("tape_out_o", tape_out_o, d[6]);
            d = ~d;
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+sim
rtl/bk_bus_pkg.sv
rtl/bk_mmu_pkg.sv
rtl/bk_sysregs.sv
rtl/bk_memmap.sv
rtl/bk_bus_steer.sv
rtl/bk_core_io.sv
sim/tb_bk_core_io.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_bk_core_io
LINT_TOP  ?= bk_core_io
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LFLAGS    ?= --lint-only --timing
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR)
